// ==== verilog/cache_pkg.sv ====
package cache_pkg;

	// address and data width, byte addresses
	localparam int word_w = 16;

	// address split: tag 15..9, index 8..4, word offset 3..1, bit 0 unused
	localparam int offset_w = 3;
	localparam int index_w = 5;
	localparam int tag_w = word_w - index_w - offset_w - 1;  // 7

	// geometry
	localparam int words_per_block = 1 << offset_w;  // 8 words, 16 bytes
	localparam int num_sets = 1 << index_w;          // 32 sets

	// main memory read latency in cycles, enable to valid
	localparam int mem_latency = 4;

	// one data word or one byte address
	typedef logic [word_w-1:0] word_t;

	// stored tag
	typedef logic [tag_w-1:0] tag_t;

	// set index
	typedef logic [index_w-1:0] index_t;

	// word inside a block
	typedef logic [offset_w-1:0] offset_t;

	// data array row, {index, offset}
	typedef logic [index_w+offset_w-1:0] data_addr_t;

	// memory word address, byte address bits 15..1
	typedef logic [word_w-2:0] mem_addr_t;

endpackage

// ==== verilog/cache_array.sv ====
`timescale 1ns/1ps

// single-port synchronous array, one write port and one registered read port
// payload type set per instance (tags or data words)
module cache_array #(
	parameter type entry_t = cache_pkg::word_t,
	parameter int depth = 32
) (
	input  logic                     clk,
	input  logic                     wr,       // write strobe
	input  logic [$clog2(depth)-1:0] wr_addr,
	input  entry_t                   wr_data,
	input  logic [$clog2(depth)-1:0] rd_addr,  // sampled every cycle
	output entry_t                   rd_data   // valid one cycle after rd_addr
);

	// storage, contents undefined until written
	entry_t mem [depth];

	// write side
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read side
	// a read and a write of the same row in one cycle see the old entry,
	// both sides use nonblocking updates on the same edge
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ps

// word-wide main memory behind the cache
// preload port writes in the same cycle, read path is a fixed pipeline
module main_memory (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mem_wr,             // preload strobe
	input  cache_pkg::word_t mem_wr_addr,        // byte address
	input  cache_pkg::word_t mem_wr_data,
	input  logic             memory_enable,      // read strobe
	input  cache_pkg::word_t memory_address,     // byte address
	output logic             memory_data_valid,  // mem_latency cycles after enable
	output cache_pkg::word_t memory_data
);

	// 32K words, indexed by byte address bits 15..1
	cache_pkg::word_t mem [1 << (cache_pkg::word_w - 1)];

	// valid travels through mem_latency stages
	logic [cache_pkg::mem_latency-1:0] valid_pipe;

	// address travels one stage less, last stage is the data register
	cache_pkg::mem_addr_t addr_pipe [cache_pkg::mem_latency-1];

	// data register at the end of the pipe
	cache_pkg::word_t data_q;

	// preload writes
	always_ff @(posedge clk) begin
		if (mem_wr) begin
			mem[mem_wr_addr[cache_pkg::word_w-1:1]] <= mem_wr_data;
		end
	end

	// valid shift register, one new read per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[cache_pkg::mem_latency-2:0], memory_enable};
		end
	end

	// address stages, then the array read into data_q
	always_ff @(posedge clk) begin
		if (memory_enable) begin
			addr_pipe[0] <= memory_address[cache_pkg::word_w-1:1];  // drop byte bit
		end
		for (int i = 1; i < cache_pkg::mem_latency - 1; i++) begin
			addr_pipe[i] <= addr_pipe[i-1];
		end
		data_q <= mem[addr_pipe[cache_pkg::mem_latency-2]];  // lines up with last valid stage
	end

	assign memory_data_valid = valid_pipe[cache_pkg::mem_latency-1];
	assign memory_data = data_q;  // in issue order

endmodule

// ==== verilog/cache_fill_fsm.sv ====
`timescale 1ns/1ps

// block fill on a miss
// sends the 8 word reads of the block back to back, writes each word into
// the data array as it returns, then writes the tag and signals done
module cache_fill_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   miss_detected,      // one-cycle pulse
	input  cache_pkg::word_t       miss_address,
	output logic                   fill_busy,
	output logic                   fill_done,          // same cycle as the tag write
	output logic                   memory_enable,
	output cache_pkg::word_t       memory_address,
	input  logic                   memory_data_valid,
	input  cache_pkg::word_t       memory_data,
	output logic                   write_data_array,
	output cache_pkg::data_addr_t  write_address,
	output cache_pkg::word_t       write_data,
	output logic                   write_tag_array,
	output cache_pkg::tag_t        write_tag
);

	typedef enum logic {
		st_idle,
		st_fill
	} state_t;

	state_t state;

	// counts run 0..8, bit 3 set means the block is done
	logic [cache_pkg::offset_w:0] issue_cnt;  // reads sent
	logic [cache_pkg::offset_w:0] ret_cnt;    // words back

	// block being filled, latched from the miss address
	cache_pkg::tag_t base_tag;
	cache_pkg::index_t base_index;

	logic in_fill;
	logic block_back;  // all 8 words written

	assign in_fill = (state == st_fill);
	assign block_back = (ret_cnt == cache_pkg::words_per_block);

	assign fill_busy = in_fill;  // from the cycle after the miss to the tag write

	// read side, up to mem_latency reads in flight
	assign memory_enable = in_fill && (issue_cnt < cache_pkg::words_per_block);
	assign memory_address = {base_tag, base_index, issue_cnt[cache_pkg::offset_w-1:0], 1'b0};

	// returning words go straight into the data array
	assign write_data_array = in_fill && memory_data_valid;
	assign write_address = {base_index, ret_cnt[cache_pkg::offset_w-1:0]};
	assign write_data = memory_data;

	// tag goes in one cycle after the 8th word
	assign write_tag_array = in_fill && block_back;
	assign write_tag = base_tag;
	assign fill_done = write_tag_array;

	// state and counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			issue_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (miss_detected) begin
						state <= st_fill;
						issue_cnt <= '0;
						ret_cnt <= '0;
					end
				end
				st_fill: begin
					if (memory_enable) begin
						issue_cnt <= issue_cnt + 1'b1;  // next word offset
					end
					if (memory_data_valid) begin
						ret_cnt <= ret_cnt + 1'b1;
					end
					if (write_tag_array) begin
						state <= st_idle;  // done with this block
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// block base, held for the whole fill
	always_ff @(posedge clk) begin
		if (!in_fill && miss_detected) begin
			base_tag <= miss_address[cache_pkg::word_w-1 -: cache_pkg::tag_w];
			base_index <= miss_address[cache_pkg::offset_w+1 +: cache_pkg::index_w];
		end
	end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps

// lookup side of the cache
// hit: read arrays, compare, respond 2 cycles after req
// miss: hand off to the fill FSM, set valid, re-read the word, respond
module cache_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  cache_pkg::word_t      req_addr,
	output logic                  busy,
	output logic                  rsp_valid,
	output cache_pkg::word_t      rsp_data,
	output logic                  rsp_hit,
	output cache_pkg::index_t     tag_rd_addr,
	input  cache_pkg::tag_t       tag_rd_data,
	output cache_pkg::data_addr_t data_rd_addr,
	input  cache_pkg::word_t      data_rd_data,
	output logic                  miss_detected,
	output cache_pkg::word_t      miss_address,
	input  logic                  fill_busy,
	input  logic                  fill_done
);

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,   // array outputs valid, compare
		st_miss,     // waiting on the fill
		st_reread,   // data word read after the fill
		st_respond
	} state_t;

	state_t state;
	cache_pkg::word_t req_q;        // request being served
	cache_pkg::word_t look_addr;    // address in front of the arrays
	cache_pkg::tag_t look_tag;
	cache_pkg::index_t look_index;
	cache_pkg::offset_t look_offset;
	logic [cache_pkg::num_sets-1:0] valid_q;  // one per set
	logic hit;

	// new address only while idle, else keep reading the latched one
	assign look_addr = (state == st_idle) ? req_addr : req_q;
	assign look_tag = look_addr[cache_pkg::word_w-1 -: cache_pkg::tag_w];
	assign look_index = look_addr[cache_pkg::offset_w+1 +: cache_pkg::index_w];
	assign look_offset = look_addr[1 +: cache_pkg::offset_w];
	assign tag_rd_addr = look_index;
	assign data_rd_addr = {look_index, look_offset};
	assign hit = valid_q[look_index] && (tag_rd_data == look_tag);  // meaningful in st_lookup
	assign busy = (state != st_idle) || fill_busy;
	assign rsp_valid = (state == st_respond);
	assign miss_address = req_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			valid_q <= '0;
			miss_detected <= 1'b0;
		end else begin
			miss_detected <= 1'b0;  // single-cycle pulse
			case (state)
				st_idle: if (req) state <= st_lookup;
				st_lookup: begin
					if (hit) begin
						state <= st_respond;
					end else begin
						state <= st_miss;
						miss_detected <= 1'b1;
					end
				end
				st_miss: begin
					if (fill_done) begin
						valid_q[look_index] <= 1'b1;  // tag lands this same edge
						state <= st_reread;
					end
				end
				st_reread: state <= st_respond;
				st_respond: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (state == st_idle && req) begin
			req_q <= req_addr;
		end
		if ((state == st_lookup && hit) || state == st_reread) begin
			rsp_data <= data_rd_data;
			rsp_hit <= (state == st_lookup);  // low after a fill
		end
	end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps

// instruction cache top: controller, fill FSM, tag and data arrays, memory
module cache_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req,
	input  cache_pkg::word_t req_addr,
	output logic             busy,
	output logic             rsp_valid,
	output cache_pkg::word_t rsp_data,
	output logic             rsp_hit,
	input  logic             mem_wr,       // preload only
	input  cache_pkg::word_t mem_wr_addr,
	input  cache_pkg::word_t mem_wr_data
);

	cache_pkg::index_t tag_rd_addr;
	cache_pkg::tag_t tag_rd_data;
	cache_pkg::data_addr_t data_rd_addr;
	cache_pkg::word_t data_rd_data;
	logic miss_detected;
	cache_pkg::word_t miss_address;
	logic fill_busy;
	logic fill_done;
	logic memory_enable;
	cache_pkg::word_t memory_address;
	logic memory_data_valid;
	cache_pkg::word_t memory_data;
	logic write_data_array;
	cache_pkg::data_addr_t write_address;
	cache_pkg::word_t write_data;
	logic write_tag_array;
	cache_pkg::tag_t write_tag;

	cache_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_addr(req_addr), .busy(busy),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_hit(rsp_hit),
		.tag_rd_addr(tag_rd_addr), .tag_rd_data(tag_rd_data),
		.data_rd_addr(data_rd_addr), .data_rd_data(data_rd_data),
		.miss_detected(miss_detected), .miss_address(miss_address),
		.fill_busy(fill_busy), .fill_done(fill_done)
	);

	cache_fill_fsm u_fill_fsm (
		.clk(clk), .rst_n(rst_n),
		.miss_detected(miss_detected), .miss_address(miss_address),
		.fill_busy(fill_busy), .fill_done(fill_done),
		.memory_enable(memory_enable), .memory_address(memory_address),
		.memory_data_valid(memory_data_valid), .memory_data(memory_data),
		.write_data_array(write_data_array), .write_address(write_address),
		.write_data(write_data),
		.write_tag_array(write_tag_array), .write_tag(write_tag)
	);

	// tag row is the index part of the fill write address
	cache_array #(.entry_t(cache_pkg::tag_t), .depth(cache_pkg::num_sets)) u_tag_array (
		.clk(clk), .wr(write_tag_array),
		.wr_addr(write_address[cache_pkg::offset_w +: cache_pkg::index_w]),
		.wr_data(write_tag), .rd_addr(tag_rd_addr), .rd_data(tag_rd_data)
	);

	cache_array #(
		.entry_t(cache_pkg::word_t),
		.depth(cache_pkg::num_sets * cache_pkg::words_per_block)
	) u_data_array (
		.clk(clk), .wr(write_data_array), .wr_addr(write_address),
		.wr_data(write_data), .rd_addr(data_rd_addr), .rd_data(data_rd_data)
	);

	main_memory u_memory (
		.clk(clk), .rst_n(rst_n),
		.mem_wr(mem_wr), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
		.memory_enable(memory_enable), .memory_address(memory_address),
		.memory_data_valid(memory_data_valid), .memory_data(memory_data)
	);

endmodule

// ==== verification/cache_sva.sv ====
`timescale 1ns/1ps

// protocol checks bound into the cache top level
module cache_sva (
	input logic             clk,
	input logic             rst_n,
	input logic             req,
	input logic             busy,
	input logic             rsp_valid,
	input logic             rsp_hit,
	input logic             memory_enable,   // fill read strobe
	input cache_pkg::word_t memory_address,
	input cache_pkg::word_t miss_address     // block being filled
);

	localparam int blk_lsb = cache_pkg::offset_w + 1;  // lowest block-number bit

	// requester honours busy
	a_req_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> !busy)
		else $error("req strobe while busy");

	// a hit answers 2 cycles after its req
	a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(rsp_valid && rsp_hit) |-> $past(req, 2))
		else $error("hit response not 2 cycles after req");

	// fill reads stay inside the missed block
	a_fill_in_block: assert property (@(posedge clk) disable iff (!rst_n)
		memory_enable |->
			(memory_address[cache_pkg::word_w-1:blk_lsb] ==
				miss_address[cache_pkg::word_w-1:blk_lsb]))
		else $error("fill read outside the missed block");

endmodule

bind cache_top cache_sva u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.req(req),
	.busy(busy),
	.rsp_valid(rsp_valid),
	.rsp_hit(rsp_hit),
	.memory_enable(memory_enable),
	.memory_address(memory_address),
	.miss_address(miss_address)
);

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps

// table-driven testbench for the instruction cache
module cache_tb;

	localparam int unsigned seed = 32'hf83f_cd9e;
	localparam int timeout_cycles = 100;  // per wait
	localparam int hit_latency = 2;       // array read, then compare
	localparam int miss_latency = 17;     // lookup 2, fill 13, re-read 2
	localparam int mem_words = 1 << (cache_pkg::word_w - 1);
	localparam int rows = cache_pkg::num_sets * cache_pkg::words_per_block;

	// one table entry
	typedef struct {
		logic             is_preload;
		cache_pkg::word_t addr;
		cache_pkg::word_t data;     // preload value only
		logic             exp_hit;  // read only
	} step_t;

	logic clk;
	logic rst_n;
	logic req;
	cache_pkg::word_t req_addr;
	logic busy;
	logic rsp_valid;
	cache_pkg::word_t rsp_data;
	logic rsp_hit;
	logic mem_wr;
	cache_pkg::word_t mem_wr_addr;
	cache_pkg::word_t mem_wr_data;

	cache_pkg::word_t mem_model [mem_words];  // what memory holds now
	cache_pkg::word_t line_model [rows];      // what the cache copied at fill time
	step_t steps [$];

	cache_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_addr(req_addr), .busy(busy),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_hit(rsp_hit),
		.mem_wr(mem_wr), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
	);

	always #5 clk = ~clk;  // 10 ns period

	task automatic check_word(string name, cache_pkg::word_t got, cache_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_hit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_cycles(string name, int got, int exp);
		if (got != exp) begin
			$display("FAIL %s: got 0x%h cycles, expected 0x%h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "latency mismatch");
		end
	endtask

	task automatic fail_timeout(string what);
		$display("timeout: %s did not happen within %0d cycles", what, timeout_cycles);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	endtask

	// sampled mid-cycle away from the drive edge
	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (busy) begin
			n++;
			if (n > timeout_cycles) fail_timeout("busy going low");
			@(negedge clk);
		end
	endtask

	// counts cycles from the req cycle to the rsp_valid cycle
	task automatic wait_response(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout_cycles) fail_timeout("rsp_valid");
			check_hit("busy", busy, 1'b1);  // held through the response cycle
		end while (!rsp_valid);
	endtask

	// leaves mem_wr high so writes can run back to back
	task automatic write_word(cache_pkg::word_t addr, cache_pkg::word_t data);
		@(posedge clk);
		mem_wr <= 1'b1;
		mem_wr_addr <= addr;
		mem_wr_data <= data;
		mem_model[addr[cache_pkg::word_w-1:1]] = data;
	endtask

	task automatic stop_writes();
		@(posedge clk);
		mem_wr <= 1'b0;
	endtask

	task automatic read_and_check(cache_pkg::word_t addr, logic exp_hit);
		int cycles;
		cache_pkg::index_t idx;
		cache_pkg::data_addr_t row;
		idx = addr[cache_pkg::offset_w+1 +: cache_pkg::index_w];
		row = {idx, addr[1 +: cache_pkg::offset_w]};
		if (!exp_hit) begin  // a miss copies the whole block as memory holds it now
			for (int i = 0; i < cache_pkg::words_per_block; i++) begin
				line_model[{idx, cache_pkg::offset_t'(i)}] =
					mem_model[{addr[cache_pkg::word_w-1:cache_pkg::offset_w+1],
						cache_pkg::offset_t'(i)}];
			end
		end
		wait_idle();
		@(posedge clk);
		req <= 1'b1;
		req_addr <= addr;
		@(posedge clk);
		req <= 1'b0;  // one-cycle strobe
		wait_response(cycles);
		check_hit("rsp_hit", rsp_hit, exp_hit);
		check_word("rsp_data", rsp_data, line_model[row]);
		check_cycles("req to rsp_valid", cycles, exp_hit ? hit_latency : miss_latency);
		@(negedge clk);
		check_hit("rsp_valid", rsp_valid, 1'b0);  // single pulse
		check_hit("busy", busy, 1'b0);
	endtask

	function automatic void add_read(cache_pkg::word_t addr, logic exp_hit);
		step_t s;
		s.is_preload = 1'b0;
		s.addr = addr;
		s.data = '0;
		s.exp_hit = exp_hit;
		steps.push_back(s);
	endfunction

	function automatic void add_preload(cache_pkg::word_t addr, cache_pkg::word_t data);
		step_t s;
		s.is_preload = 1'b1;
		s.addr = addr;
		s.data = data;
		s.exp_hit = 1'b0;
		steps.push_back(s);
	endfunction

	initial begin
		void'($urandom(seed));
		clk = 1'b0;
		rst_n = 1'b0;
		req = 1'b0;
		req_addr = '0;
		mem_wr = 1'b0;
		mem_wr_addr = '0;
		mem_wr_data = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_hit("busy", busy, 1'b0);
		check_hit("rsp_valid", rsp_valid, 1'b0);

		// whole memory gets random words
		for (int i = 0; i < mem_words; i++) begin
			write_word(cache_pkg::word_t'(i << 1), cache_pkg::word_t'($urandom));
		end
		stop_writes();

		// cold miss on block A (tag 0x12 index 3) then the other 7 words hit
		add_read(16'h2436, 1'b0);
		add_read(16'h2430, 1'b1);
		add_read(16'h2432, 1'b1);
		add_read(16'h2434, 1'b1);
		add_read(16'h2438, 1'b1);
		add_read(16'h243a, 1'b1);
		add_read(16'h243c, 1'b1);
		add_read(16'h243e, 1'b1);
		// tag 0x25 on index 3 evicts A and A evicts it back
		add_read(16'h4a30, 1'b0);
		add_read(16'h4a3e, 1'b1);
		add_read(16'h2436, 1'b0);
		add_read(16'h4a30, 1'b0);
		add_read(16'h2430, 1'b0);
		// memory change behind a cached word stays invisible
		add_preload(16'h2438, ~mem_model[16'h2438 >> 1]);
		add_read(16'h2438, 1'b1);
		add_read(16'h243a, 1'b1);
		// indices 5, 0x17 and 0 next to index 3
		add_read(16'h1050, 1'b0);
		add_read(16'h7f70, 1'b0);
		add_read(16'h0004, 1'b0);
		add_read(16'h1052, 1'b1);
		add_read(16'h7f7e, 1'b1);
		add_read(16'h000e, 1'b1);
		add_read(16'h2438, 1'b1);
		add_read(16'h105e, 1'b1);
		add_read(16'h7f74, 1'b1);
		add_read(16'h0005, 1'b1);  // byte bit ignored so still word 2

		for (int i = 0; i < steps.size(); i++) begin
			if (steps[i].is_preload) begin
				write_word(steps[i].addr, steps[i].data);
				stop_writes();
			end else begin
				read_and_check(steps[i].addr, steps[i].exp_hit);
			end
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/cache_pkg.sv
verilog/cache_array.sv
verilog/main_memory.sv
verilog/cache_fill_fsm.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verification/cache_sva.sv
verification/cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cache_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := STATUS: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# fails on the fail message in the log or on a nonzero exit
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
